// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvdiv_tb
FILELIST  ?= rvdiv.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/rvdiv_core.sv ====
`timescale 1ns/1ps

module rvdiv_core (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid_i,
    input  rvdiv_pkg::div_ctrl_t        ctrl_i,
    input  rvdiv_pkg::div_special_t     special_i,
    input  logic [rvdiv_pkg::EXT_W-1:0] dividend_i,
    input  logic [rvdiv_pkg::EXT_W-1:0] divisor_i,
    input  logic [5:0]                  shift_i,
    input  logic                        full_i,
    output logic                        ready_o,
    output logic                        load_o,
    output rvdiv_pkg::div_ctrl_t        ctrl_o,
    output rvdiv_pkg::div_special_t     special_o,
    output logic [rvdiv_pkg::XLEN-1:0]  quot_o,
    output logic [rvdiv_pkg::XLEN-1:0]  rem_o
);

    import rvdiv_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t           state;
    div_ctrl_t        ctrl_q;
    logic [CNT_W-1:0] count_q;
    logic [EXT_W-1:0] a_q;      // Partial remainder
    logic [XLEN-1:0]  q_q;      // Dividend bits out, quotient bits in
    logic [EXT_W-1:0] m_q;
    logic [XLEN-1:0]  low_mask;
    logic [EXT_W-1:0] a_shl;
    logic [EXT_W-1:0] a_step;
    logic [EXT_W-1:0] a_fix;
    logic             accept;
    logic             last;
    logic             fix_step;

    assign ready_o  = (state == S_IDLE) & ~full_i;
    assign accept   = valid_i & ready_o;
    assign last     = count_q == (ctrl_q.rem ? CNT_W'(REM_STEPS) : CNT_W'(QNT_STEPS));
    assign fix_step = count_q == CNT_W'(QNT_STEPS);   // Reached before last only for REM
    assign low_mask = ~({XLEN{1'b1}} << shift_i);

    //////////////////////////////////////////////////
    // Non-restoring step

    assign a_shl  = {a_q[XLEN-1:0], q_q[XLEN-1]};
    assign a_step = a_q[XLEN] ? a_shl + m_q : a_shl - m_q;
    assign a_fix  = a_q[XLEN] ? a_q + m_q : a_q;

    //////////////////////////////////////////////////
    // Sequencer

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= S_IDLE;
            ctrl_q  <= '0;
            count_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        ctrl_q  <= ctrl_i;
                        count_q <= {1'b0, shift_i};
                        if (!special_i.hit) begin
                            state <= S_RUN;
                        end
                    end
                end
                S_RUN: begin
                    if (last) begin
                        state <= S_IDLE;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            if (accept) begin
                m_q <= divisor_i;
                a_q <= {1'b0, dividend_i[XLEN-1:0] & low_mask};
                q_q <= dividend_i[XLEN-1:0] & ~low_mask;
            end
        end else if (!last) begin
            if (fix_step) begin
                a_q <= a_fix;   // Restore a negative remainder
            end else begin
                a_q <= a_step;
                q_q <= {q_q[XLEN-2:0], ~a_step[XLEN]};
            end
        end
    end

    // Specials go straight to the result register on acceptance
    assign load_o = (state == S_IDLE) ? (accept & special_i.hit) : last;
    assign ctrl_o = (state == S_IDLE) ? ctrl_i : ctrl_q;

    always_comb begin
        special_o.hit   = (state == S_IDLE) & special_i.hit;
        special_o.value = special_i.value;
    end

    assign quot_o = q_q;
    assign rem_o  = a_q[XLEN-1:0];

endmodule

// ==== design/rvdiv_norm.sv ====
`timescale 1ns/1ps

module rvdiv_norm (
    input  logic [rvdiv_pkg::EXT_W-1:0] opr_a_i,
    input  logic [rvdiv_pkg::EXT_W-1:0] opr_b_i,
    output logic [5:0]                  shift_o
);

    import rvdiv_pkg::*;

    logic [2:0] a_pos;
    logic [2:0] b_pos;
    logic [3:0] pos_diff;

    // Highest byte holding more than sign bits, byte 0 as fallback
    function automatic logic [2:0] lead_byte(input logic [EXT_W-1:0] v);
        logic [2:0] pos;
        pos = 3'd0;
        for (int k = 1; k < XLEN / 8; k++) begin
            if (v[8*k +: 8] != {8{v[XLEN]}}) begin
                pos = 3'(k);
            end
        end
        return pos;
    endfunction

    assign a_pos    = lead_byte(opr_a_i);
    assign b_pos    = lead_byte(opr_b_i);
    assign pos_diff = {1'b0, a_pos} - {1'b0, b_pos};

    always_comb begin
        if (pos_diff[3]) begin
            shift_o = 6'd63;    // Dividend below divisor, one step left
        end else begin
            shift_o = 6'd56 - {pos_diff[2:0], 3'b000};
        end
    end

endmodule

// ==== design/rvdiv_pkg.sv ====
package rvdiv_pkg;

    localparam int XLEN      = 64;
    localparam int WLEN      = 32;
    localparam int EXT_W     = XLEN + 1;    // Guard bit for the partial remainder sign
    localparam int CNT_W     = 7;
    localparam int QNT_STEPS = XLEN;
    localparam int REM_STEPS = XLEN + 1;    // One more for the remainder fix

    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_func_t;

    typedef struct packed {
        logic [WLEN-1:0] hi;
        logic [WLEN-1:0] lo;
    } div_halves_t;

    // Full double word, or two words when the word flag is set
    typedef union packed {
        logic [XLEN-1:0] dword;
        div_halves_t     half;
    } div_operand_t;

    typedef struct packed {
        logic word;
        logic rem;
        logic sgn;
        logic neg_q;
        logic neg_r;
    } div_ctrl_t;

    typedef struct packed {
        logic            hit;
        logic [XLEN-1:0] value;
    } div_special_t;

endpackage

// ==== design/rvdiv_prep.sv ====
`timescale 1ns/1ps

module rvdiv_prep (
    input  rvdiv_pkg::div_func_t        func_i,
    input  logic                        word_i,
    input  rvdiv_pkg::div_operand_t     opr_a_i,
    input  rvdiv_pkg::div_operand_t     opr_b_i,
    output rvdiv_pkg::div_ctrl_t        ctrl_o,
    output rvdiv_pkg::div_special_t     special_o,
    output logic [rvdiv_pkg::EXT_W-1:0] dividend_o,
    output logic [rvdiv_pkg::EXT_W-1:0] divisor_o,
    output logic [5:0]                  shift_o
);

    import rvdiv_pkg::*;

    logic              rem_op;
    logic              sgn_op;
    logic [XLEN-1:0]   a_ext;
    logic [XLEN-1:0]   b_ext;
    logic [EXT_W-1:0]  a_m;
    logic [EXT_W-1:0]  b_m;
    logic [EXT_W-1:0]  a_abs;
    logic [EXT_W-1:0]  b_abs;
    logic              a_min;
    logic              zero_div;
    logic              ovf;
    logic              zero_dvd;
    logic [2*XLEN-1:0] a_rot;

    assign rem_op = (func_i == REM) || (func_i == REMU);
    assign sgn_op = (func_i == DIV) || (func_i == REM);

    // Word ops only look at the low half
    always_comb begin
        if (word_i) begin
            a_ext = {{WLEN{sgn_op & opr_a_i.half.lo[WLEN-1]}}, opr_a_i.half.lo};
            b_ext = {{WLEN{sgn_op & opr_b_i.half.lo[WLEN-1]}}, opr_b_i.half.lo};
        end else begin
            a_ext = opr_a_i.dword;
            b_ext = opr_b_i.dword;
        end
    end

    assign a_m   = {sgn_op & a_ext[XLEN-1], a_ext};
    assign b_m   = {sgn_op & b_ext[XLEN-1], b_ext};
    assign a_abs = a_m[XLEN] ? -a_m : a_m;
    assign b_abs = b_m[XLEN] ? -b_m : b_m;

    //////////////////////////////////////////////////
    // Special cases

    assign a_min = word_i ? (a_ext == {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}})
                          : (a_ext == {1'b1, {(XLEN-1){1'b0}}});

    assign zero_div = (b_ext == '0);
    assign ovf      = sgn_op & a_min & (b_ext == '1);
    assign zero_dvd = (a_ext == '0);

    always_comb begin
        special_o.hit = zero_div | ovf | zero_dvd;
        if (zero_div) begin
            special_o.value = rem_op ? a_ext : '1;
        end else if (ovf) begin
            special_o.value = rem_op ? '0 : a_ext;
        end else begin
            special_o.value = '0;       // Zero dividend
        end
    end

    //////////////////////////////////////////////////
    // Loop start state

    always_comb begin
        ctrl_o.word  = word_i;
        ctrl_o.rem   = rem_op;
        ctrl_o.sgn   = sgn_op;
        ctrl_o.neg_q = a_m[XLEN] ^ b_m[XLEN];
        ctrl_o.neg_r = a_m[XLEN];   // Remainder follows the dividend
    end

    rvdiv_norm u_norm (
        .opr_a_i (a_abs),
        .opr_b_i (b_abs),
        .shift_o (shift_o)
    );

    // Rotate so the skipped top bits sit at the bottom for the remainder
    assign a_rot      = {a_abs[XLEN-1:0], a_abs[XLEN-1:0]} << shift_o;
    assign dividend_o = {1'b0, a_rot[2*XLEN-1:XLEN]};
    assign divisor_o  = b_abs;

endmodule

// ==== design/rvdiv_result.sv ====
`timescale 1ns/1ps

module rvdiv_result (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       load_i,
    input  rvdiv_pkg::div_ctrl_t       ctrl_i,
    input  rvdiv_pkg::div_special_t    special_i,
    input  logic [rvdiv_pkg::XLEN-1:0] quot_i,
    input  logic [rvdiv_pkg::XLEN-1:0] rem_i,
    input  logic                       res_ready_i,
    output logic [rvdiv_pkg::XLEN-1:0] res_o,
    output logic                       res_valid_o,
    output logic                       full_o
);

    import rvdiv_pkg::*;

    logic [XLEN-1:0] quot_fix;
    logic [XLEN-1:0] rem_fix;
    div_operand_t    raw;
    logic [XLEN-1:0] res_d;
    logic [XLEN-1:0] res_q;
    logic            valid_q;

    // Loop works on magnitudes, signs come back here
    assign quot_fix = ctrl_i.neg_q ? -quot_i : quot_i;
    assign rem_fix  = ctrl_i.neg_r ? -rem_i : rem_i;

    always_comb begin
        if (special_i.hit) begin
            raw.dword = special_i.value;
        end else if (ctrl_i.rem) begin
            raw.dword = rem_fix;
        end else begin
            raw.dword = quot_fix;
        end
    end

    assign res_d = ctrl_i.word ? {{WLEN{raw.half.lo[WLEN-1]}}, raw.half.lo} : raw.dword;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (res_ready_i) begin
            valid_q <= 1'b0;    // Consumed
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            res_q <= res_d;
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = valid_q;
    assign full_o      = valid_q; // Blocks new requests while held

endmodule

// ==== design/rvdiv_top.sv ====
`timescale 1ns/1ps

module rvdiv_top (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       valid_i,
    input  rvdiv_pkg::div_func_t       func_i,
    input  logic                       word_i,
    input  rvdiv_pkg::div_operand_t    opr_a_i,
    input  rvdiv_pkg::div_operand_t    opr_b_i,
    output logic                       ready_o,
    output logic [rvdiv_pkg::XLEN-1:0] res_o,
    output logic                       res_valid_o,
    input  logic                       res_ready_i
);

    import rvdiv_pkg::*;

    div_ctrl_t        prep_ctrl;
    div_special_t     prep_special;
    logic [EXT_W-1:0] dividend;
    logic [EXT_W-1:0] divisor;
    logic [5:0]       shift;

    div_ctrl_t        core_ctrl;
    div_special_t     core_special;
    logic             load;
    logic [XLEN-1:0]  quot;
    logic [XLEN-1:0]  rem;
    logic             full;

    rvdiv_prep u_prep (
        .func_i     (func_i),
        .word_i     (word_i),
        .opr_a_i    (opr_a_i),
        .opr_b_i    (opr_b_i),
        .ctrl_o     (prep_ctrl),
        .special_o  (prep_special),
        .dividend_o (dividend),
        .divisor_o  (divisor),
        .shift_o    (shift)
    );

    rvdiv_core u_core (
        .clk        (clk),
        .resetn     (resetn),
        .valid_i    (valid_i),
        .ctrl_i     (prep_ctrl),
        .special_i  (prep_special),
        .dividend_i (dividend),
        .divisor_i  (divisor),
        .shift_i    (shift),
        .full_i     (full),
        .ready_o    (ready_o),
        .load_o     (load),
        .ctrl_o     (core_ctrl),
        .special_o  (core_special),
        .quot_o     (quot),
        .rem_o      (rem)
    );

    rvdiv_result u_result (
        .clk         (clk),
        .resetn      (resetn),
        .load_i      (load),
        .ctrl_i      (core_ctrl),
        .special_i   (core_special),
        .quot_i      (quot),
        .rem_i       (rem),
        .res_ready_i (res_ready_i),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .full_o      (full)
    );

endmodule

// ==== rvdiv.f ====
design/rvdiv_pkg.sv
design/rvdiv_norm.sv
design/rvdiv_prep.sv
design/rvdiv_core.sv
design/rvdiv_result.sv
design/rvdiv_top.sv
verif/rvdiv_sva.sv
verif/rvdiv_tb.sv

// ==== verif/rvdiv_sva.sv ====
`timescale 1ns/1ps

module rvdiv_sva (
    input logic                       clk,
    input logic                       resetn,
    input logic                       ready_o,
    input logic [rvdiv_pkg::XLEN-1:0] res_o,
    input logic                       res_valid_o,
    input logic                       res_ready_i
);

    // Held result stays put until taken
    res_hold_a: assert property (@(posedge clk) disable iff (!resetn)
        (res_valid_o && !res_ready_i) |=> ($stable(res_o) && res_valid_o))
        else $error("res_o or res_valid_o changed while the result was held");

    no_accept_when_full_a: assert property (@(posedge clk) disable iff (!resetn)
        res_valid_o |-> !ready_o)
        else $error("ready_o high while a result is held");

    reset_clears_valid_a: assert property (@(posedge clk)
        !resetn |-> !res_valid_o)
        else $error("res_valid_o high during reset");

endmodule

bind rvdiv_top rvdiv_sva u_sva (
    .clk         (clk),
    .resetn      (resetn),
    .ready_o     (ready_o),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
);

// ==== verif/rvdiv_tb.sv ====
`timescale 1ns/1ps

module rvdiv_tb;

    import rvdiv_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_OPS      = 80;
    localparam int OP_CYCLES    = 80;
    localparam int WAIT_LIMIT   = 200;

    logic            clk;
    logic            resetn;
    logic            valid;
    div_func_t       func;
    logic            word;
    div_operand_t    opr_a;
    div_operand_t    opr_b;
    logic            ready;
    logic [XLEN-1:0] res;
    logic            res_valid;
    logic            res_ready;

    int error_count;
    int check_count;

    rvdiv_top dut_i (
        .clk         (clk),
        .resetn      (resetn),
        .valid_i     (valid),
        .func_i      (func),
        .word_i      (word),
        .opr_a_i     (opr_a),
        .opr_b_i     (opr_b),
        .ready_o     (ready),
        .res_o       (res),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_OPS * OP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // Reference model and helpers

    // RISC-V M extension rules
    function automatic logic [XLEN-1:0] expected_result(input div_func_t f, input logic w,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic            sgn;
        logic            rem;
        logic [XLEN-1:0] a_x;
        logic [XLEN-1:0] b_x;
        logic [XLEN-1:0] min_val;
        logic [XLEN-1:0] q;
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] res_v;
        sgn = (f == DIV) || (f == REM);
        rem = (f == REM) || (f == REMU);
        if (w) begin
            a_x     = sgn ? {{WLEN{a[WLEN-1]}}, a[WLEN-1:0]} : {{WLEN{1'b0}}, a[WLEN-1:0]};
            b_x     = sgn ? {{WLEN{b[WLEN-1]}}, b[WLEN-1:0]} : {{WLEN{1'b0}}, b[WLEN-1:0]};
            min_val = 64'hFFFF_FFFF_8000_0000;
        end else begin
            a_x     = a;
            b_x     = b;
            min_val = 64'h8000_0000_0000_0000;
        end
        if (b_x == '0) begin
            q = '1;
            r = a_x;
        end else if (sgn && a_x == min_val && b_x == '1) begin
            q = a_x;
            r = '0;
        end else if (sgn) begin
            q = $signed(a_x) / $signed(b_x);    // Truncates toward zero
            r = $signed(a_x) % $signed(b_x);
        end else begin
            q = a_x / b_x;
            r = a_x % b_x;
        end
        res_v = rem ? r : q;
        if (w) begin
            res_v = {{WLEN{res_v[WLEN-1]}}, res_v[WLEN-1:0]};
        end
        return res_v;
    endfunction

    function automatic logic [XLEN-1:0] random_dword();
        return {$urandom, $urandom};
    endfunction

    // Random bit length, so the pre-shift varies
    function automatic logic [XLEN-1:0] short_dword();
        return random_dword() >> ($urandom % XLEN);
    endfunction

    task automatic compare_result(input string name, input logic [XLEN-1:0] expected,
            input logic [XLEN-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Called and left at 1 ns after a rising edge
    task automatic send_request(input div_func_t f, input logic w,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int waited;
        waited      = 0;
        valid       = 1'b1;
        func        = f;
        word        = w;
        opr_a.dword = a;
        opr_b.dword = b;
        while (!ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ready) begin
            $display("Request was never accepted, ready_o stayed low");
            error_count++;
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_result(output logic got);
        int waited;
        waited = 0;
        while (!res_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        got = res_valid;
        if (!got) begin
            $display("No result came back, res_valid_o stayed low");
            error_count++;
        end
    endtask

    task automatic run_op(input div_func_t f, input logic w,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic got;
        send_request(f, w, a, b);
        wait_result(got);
        if (got) begin
            compare_result($sformatf("res_o %s w=%0b", f.name(), w),
                           expected_result(f, w, a, b), res);
        end
        @(posedge clk);     // Consumed here
        #1;
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic reset_state_values();
        compare_result("ready_o", 64'd1, {63'd0, ready});
        compare_result("res_valid_o", 64'd0, {63'd0, res_valid});
    endtask

    task automatic unsigned_ops();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < 8; i++) begin
            a = short_dword();
            b = short_dword();
            run_op(DIVU, 1'b0, a, b);
            run_op(REMU, 1'b0, a, b);
        end
        for (int i = 0; i < 2; i++) begin
            b = random_dword() | 64'h4000_0000_0000_0000;
            a = (b >> (1 + $urandom % 32)) | 64'd1;     // Dividend below divisor
            run_op(DIVU, 1'b0, a, b);
            run_op(REMU, 1'b0, a, b);
        end
    endtask

    task automatic signed_ops();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 3; i++) begin
                a = (short_dword() >> 1) | 64'd1;
                b = (short_dword() >> 1) | 64'd1;
                if (s[0]) begin
                    a = -a;
                end
                if (s[1]) begin
                    b = -b;
                end
                run_op(DIV, 1'b0, a, b);
                run_op(REM, 1'b0, a, b);
            end
        end
    endtask

    task automatic word_ops();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < 4; i++) begin
            a = random_dword();
            b = {$urandom, ($urandom >> ($urandom % 28)) | 32'd1};  // Garbage upper half
            for (int f = 0; f < 4; f++) begin
                run_op(div_func_t'(f), 1'b1, a, b);
            end
        end
    endtask

    task automatic special_cases();
        for (int f = 0; f < 4; f++) begin
            run_op(div_func_t'(f), 1'b0, random_dword(), 64'd0);
            run_op(div_func_t'(f), 1'b1, random_dword(), {$urandom, 32'd0});
            run_op(div_func_t'(f), 1'b0, 64'd0, random_dword() | 64'd1);
        end
        run_op(DIV, 1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
        run_op(REM, 1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
        run_op(DIV, 1'b1, {$urandom, 32'h8000_0000}, {$urandom, 32'hFFFF_FFFF});
        run_op(REM, 1'b1, {$urandom, 32'h8000_0000}, {$urandom, 32'hFFFF_FFFF});
    endtask

    task automatic backpressure_hold();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] expected;
        int              hold;
        logic            got;
        for (int f = 0; f < 4; f++) begin
            a         = random_dword();
            b         = short_dword() | 64'd1;
            expected  = expected_result(div_func_t'(f), 1'b0, a, b);
            res_ready = 1'b0;
            send_request(div_func_t'(f), 1'b0, a, b);
            wait_result(got);
            if (got) begin
                compare_result("res_o", expected, res);
                hold = 1 + $urandom % 8;
                repeat (hold) begin
                    @(posedge clk);
                    #1;
                    compare_result("res_o", expected, res);
                    compare_result("ready_o", 64'd0, {63'd0, ready});
                    compare_result("res_valid_o", 64'd1, {63'd0, res_valid});
                end
            end
            res_ready = 1'b1;
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'h8793));
        error_count = 0;
        check_count = 0;
        resetn      = 1'b0;
        valid       = 1'b0;
        func        = DIV;
        word        = 1'b0;
        opr_a       = '0;
        opr_b       = '0;
        res_ready   = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b1;

        reset_state_values();
        unsigned_ops();
        signed_ops();
        word_ops();
        special_cases();
        backpressure_hold();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
